// File: all.f
+incdir+logic
logic/mips_pkg.sv
logic/fwd_if.sv
logic/reg_file.sv
logic/fetch_decode.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/hazard_ctrl.sv
logic/mips_core.sv
tb/mips_core_assert.sv
tb/mips_core_tb.sv

// File: logic/execute_stage.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module execute_stage (
        input  logic                 clk,
        input  logic                 rst_n,
        input  logic                 en_idex_i,
        input  logic                 bubble_i,
        input  mips_pkg::decoded_t   dec_i,
        input  logic                 en_exmm_i,
        output mips_pkg::ex_result_t res_o,
        fwd_if.producer              ex_fwd
);
        import mips_pkg::*;

        localparam decoded_t DEC_NOP = '0;

        decoded_t              id_ex;
        logic [`MIPS_XLEN-1:0] imm_ext;
        logic [`MIPS_XLEN-1:0] alu_out;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        id_ex <= DEC_NOP;
                end else if (en_idex_i) begin
                        id_ex <= bubble_i ? DEC_NOP : dec_i;
                end else if (en_exmm_i) begin
                        id_ex <= DEC_NOP;   // EX drains while ID holds.
                end
        end

        assign imm_ext = {{16{id_ex.imm[15]}}, id_ex.imm};

        always_comb begin
                case (id_ex.op)
                OP_ADDU:  alu_out = id_ex.rs_val + id_ex.rt_val;
                OP_SUBU:  alu_out = id_ex.rs_val - id_ex.rt_val;
                OP_AND:   alu_out = id_ex.rs_val & id_ex.rt_val;
                OP_OR:    alu_out = id_ex.rs_val | id_ex.rt_val;
                OP_SLT:   alu_out = {31'b0, $signed(id_ex.rs_val) < $signed(id_ex.rt_val)};
                OP_ADDIU, OP_LW, OP_SW:
                          alu_out = id_ex.rs_val + imm_ext;
                default:  alu_out = '0;
                endcase
        end

        always_comb begin
                case (id_ex.op)
                OP_LW:   res_o.mem_op = MEM_LOAD;
                OP_SW:   res_o.mem_op = MEM_STORE;
                default: res_o.mem_op = MEM_NONE;
                endcase
                res_o.dst    = id_ex.dst;
                res_o.result = alu_out;
                res_o.wdata  = id_ex.rt_val;
                res_o.we     = id_ex.dst != '0;   // Decode zeroes dst for non-writers.
        end

        assign ex_fwd.we      = res_o.we;
        assign ex_fwd.addr    = res_o.dst;
        assign ex_fwd.data    = alu_out;
        assign ex_fwd.is_load = res_o.mem_op == MEM_LOAD;
endmodule

// File: logic/fetch_decode.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module fetch_decode (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    en_pc_i,
        input  logic                    en_ifid_i,
        input  logic [`MIPS_XLEN-1:0]   inst_i,
        input  logic [`MIPS_XLEN-1:0]   rs_val_i,
        input  logic [`MIPS_XLEN-1:0]   rt_val_i,
        output logic [`MIPS_XLEN-1:0]   pc_o,
        output logic [`MIPS_REG_AW-1:0] rs_addr_o,
        output logic [`MIPS_REG_AW-1:0] rt_addr_o,
        output mips_pkg::decoded_t      dec_o,
        fwd_if.consumer                 ex_fwd,
        fwd_if.consumer                 mm_fwd
);
        import mips_pkg::*;

        logic [`MIPS_XLEN-1:0] pc_q;
        logic [`MIPS_XLEN-1:0] inst_q;
        logic [5:0]            opcode;
        logic [5:0]            funct;
        logic                  ex_ok, mm_ok;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        pc_q   <= `MIPS_RESET_PC;
                        inst_q <= '0;             // All-zero word decodes as a NOP.
                end else begin
                        if (en_pc_i)
                                pc_q <= pc_q + 32'd4;
                        if (en_ifid_i)
                                inst_q <= inst_i;
                end
        end

        assign pc_o      = pc_q;
        assign opcode    = inst_q[31:26];
        assign funct     = inst_q[5:0];
        assign rs_addr_o = inst_q[25:21];
        assign rt_addr_o = inst_q[20:16];

        // A load still in EX has no data yet; the hazard controller bubbles it away.
        assign ex_ok = ex_fwd.we && !ex_fwd.is_load && ex_fwd.addr != '0;
        assign mm_ok = mm_fwd.we && !mm_fwd.is_load && mm_fwd.addr != '0;

        function automatic logic [`MIPS_XLEN-1:0] operand(
                input logic [`MIPS_REG_AW-1:0] ra,
                input logic [`MIPS_XLEN-1:0]   rf_val
        );
                if (ex_ok && ex_fwd.addr == ra)
                        return ex_fwd.data;
                if (mm_ok && mm_fwd.addr == ra)
                        return mm_fwd.data;
                return rf_val;
        endfunction

        always_comb begin
                dec_o.op     = OP_NOP;
                dec_o.dst    = inst_q[20:16];
                dec_o.rs_val = operand(rs_addr_o, rs_val_i);
                dec_o.rt_val = operand(rt_addr_o, rt_val_i);
                dec_o.imm    = inst_q[15:0];
                case (opcode)
                `MIPS_OPC_SPECIAL: begin
                        dec_o.dst = inst_q[15:11];
                        case (funct)
                        `MIPS_FUNCT_ADDU: dec_o.op = OP_ADDU;
                        `MIPS_FUNCT_SUBU: dec_o.op = OP_SUBU;
                        `MIPS_FUNCT_AND:  dec_o.op = OP_AND;
                        `MIPS_FUNCT_OR:   dec_o.op = OP_OR;
                        `MIPS_FUNCT_SLT:  dec_o.op = OP_SLT;
                        default:          dec_o.op = OP_NOP;
                        endcase
                end
                `MIPS_OPC_ADDIU: dec_o.op = OP_ADDIU;
                `MIPS_OPC_LW:    dec_o.op = OP_LW;
                `MIPS_OPC_SW:    dec_o.op = OP_SW;
                default:         dec_o.op = OP_NOP;
                endcase
                if (dec_o.op == OP_NOP || dec_o.op == OP_SW)
                        dec_o.dst = '0;   // No register write.
        end
endmodule

// File: logic/fwd_if.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

// Pending register result of one pipeline stage, seen by decode.
interface fwd_if;
        logic                    we;
        logic [`MIPS_REG_AW-1:0] addr;
        logic [`MIPS_XLEN-1:0]   data;
        logic                    is_load;   // Data comes from the bus later.

        modport producer (
                output we,
                output addr,
                output data,
                output is_load
        );

        modport consumer (
                input we,
                input addr,
                input data,
                input is_load
        );
endinterface

// File: logic/hazard_ctrl.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module hazard_ctrl (
        input  logic                    dbus_stall_i,
        input  logic [`MIPS_REG_AW-1:0] rs_addr_i,
        input  logic [`MIPS_REG_AW-1:0] rt_addr_i,
        output logic                    en_pc_o,
        output logic                    en_ifid_o,
        output logic                    en_idex_o,
        output logic                    bubble_o,
        output logic                    en_mem_o,
        fwd_if.consumer                 ex_fwd
);
        logic load_use;

        assign load_use = ex_fwd.is_load && ex_fwd.addr != '0 &&
                          (ex_fwd.addr == rs_addr_i || ex_fwd.addr == rt_addr_i);

        always_comb begin
                {en_pc_o, en_ifid_o, en_idex_o, en_mem_o} = 4'b1111;
                bubble_o = 1'b0;
                if (dbus_stall_i) begin
                        {en_pc_o, en_ifid_o, en_idex_o, en_mem_o} = 4'b0000;
                end else if (load_use) begin
                        en_pc_o   = 1'b0;   // Hold fetch and decode one cycle.
                        en_ifid_o = 1'b0;
                        bubble_o  = 1'b1;
                end
        end
endmodule

// File: logic/mem_wb_stage.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module mem_wb_stage (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    en_i,
        input  mips_pkg::ex_result_t    res_i,
        input  logic [`MIPS_XLEN-1:0]   dbus_rddata_i,
        output logic [`MIPS_XLEN-1:0]   dbus_address_o,
        output logic                    dbus_read_o,
        output logic                    dbus_write_o,
        output logic [`MIPS_XLEN-1:0]   dbus_wrdata_o,
        output logic                    wb_we_o,
        output logic [`MIPS_REG_AW-1:0] wb_addr_o,
        output logic [`MIPS_XLEN-1:0]   wb_data_o,
        fwd_if.producer                 mm_fwd
);
        import mips_pkg::*;

        ex_result_t            ex_mm;
        logic [`MIPS_XLEN-1:0] mm_val;

        // Both registers freeze together while the data bus stalls.
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        ex_mm     <= '0;
                        wb_we_o   <= 1'b0;
                        wb_addr_o <= '0;
                        wb_data_o <= '0;
                end else if (en_i) begin
                        ex_mm     <= res_i;
                        wb_we_o   <= ex_mm.we;
                        wb_addr_o <= ex_mm.dst;
                        wb_data_o <= mm_val;
                end
        end

        assign dbus_address_o = ex_mm.result;
        assign dbus_wrdata_o  = ex_mm.wdata;
        assign dbus_read_o    = ex_mm.mem_op == MEM_LOAD;
        assign dbus_write_o   = ex_mm.mem_op == MEM_STORE;

        // Load data is valid in the cycle the transfer completes.
        assign mm_val = dbus_read_o ? dbus_rddata_i : ex_mm.result;

        assign mm_fwd.we      = ex_mm.we;
        assign mm_fwd.addr    = ex_mm.dst;
        assign mm_fwd.data    = mm_val;
        assign mm_fwd.is_load = 1'b0;   // Already on the bus by now.
endmodule

// File: logic/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Datapath and register file geometry.
`define MIPS_XLEN   32
`define MIPS_REG_AW 5
`define MIPS_NREGS  32

`define MIPS_RESET_PC 32'h0000_0000

// Primary opcode field, inst[31:26].
`define MIPS_OPC_SPECIAL 6'h00
`define MIPS_OPC_ADDIU   6'h09
`define MIPS_OPC_LW      6'h23
`define MIPS_OPC_SW      6'h2B

// Function field of SPECIAL, inst[5:0].
`define MIPS_FUNCT_ADDU 6'h21
`define MIPS_FUNCT_SUBU 6'h23
`define MIPS_FUNCT_AND  6'h24
`define MIPS_FUNCT_OR   6'h25
`define MIPS_FUNCT_SLT  6'h2A

`endif

// File: logic/mips_core.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_core (
        input  logic                  clk,
        input  logic                  rst_n,
        output logic [`MIPS_XLEN-1:0] ibus_address_o,
        input  logic [`MIPS_XLEN-1:0] ibus_rddata_i,
        output logic [`MIPS_XLEN-1:0] dbus_address_o,
        output logic                  dbus_read_o,
        output logic                  dbus_write_o,
        output logic [`MIPS_XLEN-1:0] dbus_wrdata_o,
        input  logic [`MIPS_XLEN-1:0] dbus_rddata_i,
        input  logic                  dbus_stall_i
);
        import mips_pkg::*;

        logic [`MIPS_REG_AW-1:0] rs_addr;
        logic [`MIPS_REG_AW-1:0] rt_addr;
        logic [`MIPS_XLEN-1:0]   rs_val;
        logic [`MIPS_XLEN-1:0]   rt_val;
        decoded_t                dec;
        ex_result_t              res;
        logic                    wb_we;
        logic [`MIPS_REG_AW-1:0] wb_addr;
        logic [`MIPS_XLEN-1:0]   wb_data;
        logic                    en_pc, en_ifid, en_idex, bubble, en_mem;

        fwd_if ex_fwd ();
        fwd_if mm_fwd ();

        fetch_decode u_fetch_decode (
                .clk       (clk),
                .rst_n     (rst_n),
                .en_pc_i   (en_pc),
                .en_ifid_i (en_ifid),
                .inst_i    (ibus_rddata_i),
                .rs_val_i  (rs_val),
                .rt_val_i  (rt_val),
                .pc_o      (ibus_address_o),
                .rs_addr_o (rs_addr),
                .rt_addr_o (rt_addr),
                .dec_o     (dec),
                .ex_fwd    (ex_fwd),
                .mm_fwd    (mm_fwd)
        );

        reg_file u_reg_file (
                .clk       (clk),
                .rst_n     (rst_n),
                .rs_addr_i (rs_addr),
                .rt_addr_i (rt_addr),
                .wb_we_i   (wb_we),
                .wb_addr_i (wb_addr),
                .wb_data_i (wb_data),
                .rs_val_o  (rs_val),
                .rt_val_o  (rt_val)
        );

        execute_stage u_execute_stage (
                .clk       (clk),
                .rst_n     (rst_n),
                .en_idex_i (en_idex),
                .bubble_i  (bubble),
                .dec_i     (dec),
                .en_exmm_i (en_mem),
                .res_o     (res),
                .ex_fwd    (ex_fwd)
        );

        mem_wb_stage u_mem_wb_stage (
                .clk            (clk),
                .rst_n          (rst_n),
                .en_i           (en_mem),
                .res_i          (res),
                .dbus_rddata_i  (dbus_rddata_i),
                .dbus_address_o (dbus_address_o),
                .dbus_read_o    (dbus_read_o),
                .dbus_write_o   (dbus_write_o),
                .dbus_wrdata_o  (dbus_wrdata_o),
                .wb_we_o        (wb_we),
                .wb_addr_o      (wb_addr),
                .wb_data_o      (wb_data),
                .mm_fwd         (mm_fwd)
        );

        hazard_ctrl u_hazard_ctrl (
                .dbus_stall_i (dbus_stall_i),
                .rs_addr_i    (rs_addr),
                .rt_addr_i    (rt_addr),
                .en_pc_o      (en_pc),
                .en_ifid_o    (en_ifid),
                .en_idex_o    (en_idex),
                .bubble_o     (bubble),
                .en_mem_o     (en_mem),
                .ex_fwd       (ex_fwd)
        );
endmodule

// File: logic/mips_pkg.sv
`include "mips_consts.svh"

package mips_pkg;

        typedef enum logic [3:0] {
                OP_NOP, OP_ADDU, OP_SUBU, OP_AND, OP_OR,
                OP_SLT, OP_ADDIU, OP_LW, OP_SW
        } alu_op_e;

        typedef enum logic [1:0] {
                MEM_NONE, MEM_LOAD, MEM_STORE
        } mem_op_e;

        // Output of the decode stage, operands already forwarded.
        typedef struct packed {
                alu_op_e                 op;
                logic [`MIPS_REG_AW-1:0] dst;     // Zero when nothing is written.
                logic [`MIPS_XLEN-1:0]   rs_val;
                logic [`MIPS_XLEN-1:0]   rt_val;
                logic [15:0]             imm;     // Sign extended in execute.
        } decoded_t;

        typedef struct packed {
                mem_op_e                 mem_op;
                logic [`MIPS_REG_AW-1:0] dst;
                logic [`MIPS_XLEN-1:0]   result;  // ALU value or data-bus address.
                logic [`MIPS_XLEN-1:0]   wdata;
                logic                    we;
        } ex_result_t;

endpackage

// File: logic/reg_file.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module reg_file (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic [`MIPS_REG_AW-1:0] rs_addr_i,
        input  logic [`MIPS_REG_AW-1:0] rt_addr_i,
        input  logic                    wb_we_i,
        input  logic [`MIPS_REG_AW-1:0] wb_addr_i,
        input  logic [`MIPS_XLEN-1:0]   wb_data_i,
        output logic [`MIPS_XLEN-1:0]   rs_val_o,
        output logic [`MIPS_XLEN-1:0]   rt_val_o
);
        logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < `MIPS_NREGS; i++)
                                regs[i] <= '0;
                end else if (wb_we_i && wb_addr_i != '0) begin
                        regs[wb_addr_i] <= wb_data_i;
                end
        end

        // The register being written this cycle reads as its new value.
        function automatic logic [`MIPS_XLEN-1:0] rd_port(input logic [`MIPS_REG_AW-1:0] ra);
                if (ra == '0)
                        return '0;
                if (wb_we_i && wb_addr_i == ra)
                        return wb_data_i;
                return regs[ra];
        endfunction

        assign rs_val_o = rd_port(rs_addr_i);
        assign rt_val_o = rd_port(rt_addr_i);
endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module mips_core_tb -f all.f -o mips_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# A raised error limit lets the run continue past an assertion failure.
./obj_dir/mips_core_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// File: tb/mips_core_assert.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_core_assert (
        input logic                  clk,
        input logic                  rst_n,
        input logic                  dbus_stall_i,
        input logic                  dbus_read_i,
        input logic                  dbus_write_i,
        input logic [`MIPS_XLEN-1:0] dbus_address_i,
        input logic [`MIPS_XLEN-1:0] dbus_wrdata_i,
        input logic [`MIPS_XLEN-1:0] ibus_address_i
);
        int violations = 0;   // Read by the testbench at the end of the run.

        a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
                !(dbus_read_i && dbus_write_i)) else begin
                violations++;
                $error("data bus read and write are both high");
        end

        // A stalled request keeps address, data and direction until it completes.
        a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
                dbus_stall_i |=> $stable({dbus_read_i, dbus_write_i, dbus_address_i,
                                          dbus_wrdata_i})) else begin
                violations++;
                $error("data bus outputs changed during a stall");
        end

        a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
                ibus_address_i[1:0] == 2'b00) else begin
                violations++;
                $error("instruction address is not word aligned");
        end
endmodule

// File: tb/mips_core_tb.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_core_tb;
        localparam int N_TESTS     = 5;
        localparam int PROG_LEN    = 40;
        localparam int WATCHDOG_NS = N_TESTS * (PROG_LEN * 8 + 50) * 10;

        logic        clk = 1'b0;
        logic        rst_n = 1'b0;
        logic [31:0] ibus_address, ibus_rddata, dbus_address, dbus_wrdata;
        logic        dbus_read, dbus_write;
        logic [31:0] dbus_rddata = 32'h0;
        logic        dbus_stall = 1'b0;
        logic        stall_on = 1'b0;
        logic [31:0] stall_rng = 32'h2958da99;
        logic [31:0] prog_rng = 32'h2958da99;
        logic [31:0] imem [64];
        logic [31:0] dmem [64];
        logic [31:0] exp_addr [$];
        logic [31:0] exp_data [$];
        int          got_count = 0;
        int          store_errs = 0;
        int          tests_run = 0;
        int          tests_failed = 0;

        always #5 clk = ~clk;

        mips_core DUT (
                .clk            (clk),
                .rst_n          (rst_n),
                .ibus_address_o (ibus_address),
                .ibus_rddata_i  (ibus_rddata),
                .dbus_address_o (dbus_address),
                .dbus_read_o    (dbus_read),
                .dbus_write_o   (dbus_write),
                .dbus_wrdata_o  (dbus_wrdata),
                .dbus_rddata_i  (dbus_rddata),
                .dbus_stall_i   (dbus_stall)
        );

        bind mips_core mips_core_assert u_assert (
                .clk            (clk),
                .rst_n          (rst_n),
                .dbus_stall_i   (dbus_stall_i),
                .dbus_read_i    (dbus_read_o),
                .dbus_write_i   (dbus_write_o),
                .dbus_address_i (dbus_address_o),
                .dbus_wrdata_i  (dbus_wrdata_o),
                .ibus_address_i (ibus_address_o)
        );

        // Program memory reads back zero, a NOP, outside its 64 words.
        assign ibus_rddata = (ibus_address[31:8] == 24'h0) ? imem[ibus_address[7:2]] : 32'h0;

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] s;
                s = x ^ (x << 13);
                s = s ^ (s >> 17);
                s = s ^ (s << 5);
                return s;
        endfunction

        function automatic logic [31:0] fill_word(input int i);
                return 32'h9e3779b9 * (i + 1);
        endfunction

        function automatic logic [31:0] r_type(input logic [5:0] funct,
                                               input logic [4:0] rd, rs, rt);
                return {`MIPS_OPC_SPECIAL, rs, rt, rd, 5'd0, funct};
        endfunction

        function automatic logic [31:0] i_type(input logic [5:0] opc, input logic [4:0] rt,
                                               input logic [4:0] rs, input logic [15:0] imm);
                return {opc, rs, rt, imm};
        endfunction

        // ISA model, one instruction at a time. Fills the expected store list.
        function automatic int ref_model(input int n);
                logic [31:0] rf [32];
                logic [31:0] rmem [64];
                logic [31:0] inst, a, b, addr, val;
                logic [4:0]  dst;
                logic        wr;
                int          cnt;
                for (int i = 0; i < 32; i++)
                        rf[i[4:0]] = 32'h0;
                for (int i = 0; i < 64; i++)
                        rmem[i[5:0]] = fill_word(i);
                exp_addr.delete();
                exp_data.delete();
                cnt = 0;
                for (int pc = 0; pc < n; pc++) begin
                        inst = imem[pc[5:0]];
                        a    = rf[inst[25:21]];
                        b    = rf[inst[20:16]];
                        addr = a + {{16{inst[15]}}, inst[15:0]};
                        dst  = inst[20:16];
                        wr   = 1'b1;
                        val  = 32'h0;
                        case (inst[31:26])
                        `MIPS_OPC_SPECIAL: begin
                                dst = inst[15:11];
                                case (inst[5:0])
                                `MIPS_FUNCT_ADDU: val = a + b;
                                `MIPS_FUNCT_SUBU: val = a - b;
                                `MIPS_FUNCT_AND:  val = a & b;
                                `MIPS_FUNCT_OR:   val = a | b;
                                `MIPS_FUNCT_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                                default:          wr = 1'b0;
                                endcase
                        end
                        `MIPS_OPC_ADDIU: val = addr;
                        `MIPS_OPC_LW:    val = rmem[addr[7:2]];
                        `MIPS_OPC_SW: begin
                                wr = 1'b0;
                                rmem[addr[7:2]] = b;
                                exp_addr.push_back(addr);
                                exp_data.push_back(b);
                                cnt++;
                        end
                        default: wr = 1'b0;
                        endcase
                        if (wr && dst != 5'd0)
                                rf[dst] = val;
                end
                return cnt;
        endfunction

        // Bus responses change 1 ns after the edge.
        always @(posedge clk) begin
                #1;
                dbus_rddata = dbus_read ? dmem[dbus_address[7:2]] : 32'h0;
                stall_rng   = xorshift32(stall_rng);
                dbus_stall  = stall_on && (stall_rng[2:0] < 3'd3);   // Roughly 3 cycles in 8.
        end

        always @(negedge clk) begin
                if (!rst_n) begin
                        for (int i = 0; i < 64; i++)
                                dmem[i[5:0]] = fill_word(i);
                end else if (dbus_write && !dbus_stall) begin
                        dmem[dbus_address[7:2]] = dbus_wrdata;
                end
        end

        // Every completing write is checked against the next reference store.
        always @(negedge clk) begin
                if (!rst_n) begin
                        got_count  = 0;
                        store_errs = 0;
                end else if (dbus_write && !dbus_stall) begin
                        if (got_count >= exp_addr.size()) begin
                                $display("store %0d to address %h is not in the reference list",
                                         got_count, dbus_address);
                                store_errs++;
                        end else begin
                                if (dbus_address !== exp_addr[got_count]) begin
                                        $display("ERROR dbus_address_o store %0d: expected %h, got %h",
                                                 got_count, exp_addr[got_count], dbus_address);
                                        store_errs++;
                                end
                                if (dbus_wrdata !== exp_data[got_count]) begin
                                        $display("ERROR dbus_wrdata_o store %0d: expected %h, got %h",
                                                 got_count, exp_data[got_count], dbus_wrdata);
                                        store_errs++;
                                end
                        end
                        got_count++;
                end
        end

        task automatic apply_reset();
                rst_n = 1'b0;
                repeat (10) @(posedge clk);
                #1;
                rst_n = 1'b1;
        endtask

        task automatic report_test(input string name, input int errs);
                tests_run++;
                if (errs == 0) begin
                        $display("test %0d (%s): passed", tests_run, name);
                end else begin
                        tests_failed++;
                        $display("test %0d (%s): failed with %0d errors", tests_run, name, errs);
                end
        endtask

        task automatic check_reset_outputs();
                int errs;
                errs = 0;
                apply_reset();
                if (dbus_read !== 1'b0) begin
                        $display("ERROR dbus_read_o after reset: expected 0, got %h", dbus_read);
                        errs++;
                end
                if (dbus_write !== 1'b0) begin
                        $display("ERROR dbus_write_o after reset: expected 0, got %h", dbus_write);
                        errs++;
                end
                if (ibus_address !== 32'h0) begin
                        $display("ERROR ibus_address_o after reset: expected 00000000, got %h",
                                 ibus_address);
                        errs++;
                end
                report_test("reset state", errs);
        endtask

        // The run is over once the PC is six words past the program end.
        task automatic run_program(input string name, input int n, input logic stalls);
                int exp_n;
                int errs;
                stall_on = stalls;
                exp_n = ref_model(n);
                apply_reset();
                while (ibus_address < (n + 6) * 4)
                        @(negedge clk);
                errs = store_errs;
                if (got_count != exp_n) begin
                        $display("%s: the DUT completed %0d stores but the reference made %0d",
                                 name, got_count, exp_n);
                        errs++;
                end
                report_test(name, errs);
        endtask

        task automatic clear_imem();
                for (int i = 0; i < 64; i++)
                        imem[i[5:0]] = 32'h0;
        endtask

        task automatic gen_random_program(input int n);
                logic [31:0] r;
                clear_imem();
                for (int i = 0; i < n; i++) begin
                        prog_rng = xorshift32(prog_rng);
                        r = prog_rng;
                        case (r[17:15])
                        3'd0: imem[i[5:0]] = i_type(`MIPS_OPC_ADDIU, {2'b0, r[4:2]}, {2'b0, r[7:5]},
                                                    r[31:16]);
                        3'd1: imem[i[5:0]] = r_type(`MIPS_FUNCT_ADDU, {2'b0, r[4:2]}, {2'b0, r[7:5]},
                                                    {2'b0, r[10:8]});
                        3'd2: imem[i[5:0]] = r_type(`MIPS_FUNCT_SUBU, {2'b0, r[4:2]}, {2'b0, r[7:5]},
                                                    {2'b0, r[10:8]});
                        3'd3: imem[i[5:0]] = r_type(`MIPS_FUNCT_AND, {2'b0, r[4:2]}, {2'b0, r[7:5]},
                                                    {2'b0, r[10:8]});
                        3'd4: imem[i[5:0]] = r_type(`MIPS_FUNCT_OR, {2'b0, r[4:2]}, {2'b0, r[7:5]},
                                                    {2'b0, r[10:8]});
                        3'd5: imem[i[5:0]] = r_type(`MIPS_FUNCT_SLT, {2'b0, r[4:2]}, {2'b0, r[7:5]},
                                                    {2'b0, r[10:8]});
                        3'd6: imem[i[5:0]] = i_type(`MIPS_OPC_LW, {2'b0, r[4:2]}, 5'd0,
                                                    {10'd0, r[14:11], 2'b00});
                        default: imem[i[5:0]] = i_type(`MIPS_OPC_SW, {2'b0, r[10:8]}, 5'd0,
                                                       {10'd0, r[14:11], 2'b00});
                        endcase
                end
        endtask

        initial begin
                clear_imem();
                check_reset_outputs();

                imem[0] = i_type(`MIPS_OPC_ADDIU, 5'd1, 5'd0, 16'h1234);
                imem[1] = i_type(`MIPS_OPC_ADDIU, 5'd2, 5'd0, 16'hfffb);   // r2 = -5.
                imem[2] = r_type(`MIPS_FUNCT_ADDU, 5'd3, 5'd1, 5'd2);
                imem[3] = r_type(`MIPS_FUNCT_SUBU, 5'd4, 5'd1, 5'd2);
                imem[4] = r_type(`MIPS_FUNCT_AND, 5'd5, 5'd1, 5'd2);
                imem[5] = r_type(`MIPS_FUNCT_OR, 5'd6, 5'd1, 5'd2);
                imem[6] = r_type(`MIPS_FUNCT_SLT, 5'd7, 5'd2, 5'd1);
                imem[7] = r_type(`MIPS_FUNCT_SLT, 5'd8, 5'd1, 5'd2);
                for (int k = 0; k < 6; k++)
                        imem[k[5:0] + 6'd8] = i_type(`MIPS_OPC_SW, k[4:0] + 5'd3, 5'd0,
                                                     {k[13:0], 2'b00} + 16'h10);
                run_program("ALU operations and stores", 14, 1'b0);

                clear_imem();
                imem[0] = i_type(`MIPS_OPC_ADDIU, 5'd1, 5'd0, 16'h0007);
                imem[1] = r_type(`MIPS_FUNCT_ADDU, 5'd2, 5'd1, 5'd1);
                imem[2] = r_type(`MIPS_FUNCT_ADDU, 5'd3, 5'd2, 5'd1);
                imem[3] = r_type(`MIPS_FUNCT_SUBU, 5'd4, 5'd3, 5'd2);
                imem[4] = r_type(`MIPS_FUNCT_OR, 5'd5, 5'd4, 5'd3);
                imem[5] = i_type(`MIPS_OPC_SW, 5'd5, 5'd0, 16'h0040);
                imem[6] = i_type(`MIPS_OPC_SW, 5'd4, 5'd0, 16'h0044);
                run_program("dependent ALU chain", 7, 1'b0);

                clear_imem();
                imem[0] = i_type(`MIPS_OPC_ADDIU, 5'd3, 5'd0, 16'h0003);
                imem[1] = i_type(`MIPS_OPC_SW, 5'd3, 5'd0, 16'h0030);
                imem[2] = i_type(`MIPS_OPC_LW, 5'd1, 5'd0, 16'h0030);
                imem[3] = r_type(`MIPS_FUNCT_ADDU, 5'd2, 5'd1, 5'd1);
                imem[4] = i_type(`MIPS_OPC_SW, 5'd2, 5'd0, 16'h0034);
                imem[5] = i_type(`MIPS_OPC_LW, 5'd4, 5'd0, 16'h0020);
                imem[6] = i_type(`MIPS_OPC_SW, 5'd4, 5'd0, 16'h0038);
                run_program("load-use bubble", 7, 1'b0);

                gen_random_program(PROG_LEN);
                run_program("random program under bus stall", PROG_LEN, 1'b1);

                $display("%0d tests run, %0d passed, %0d failed",
                         tests_run, tests_run - tests_failed, tests_failed);
                if (tests_failed == 0 && DUT.u_assert.violations == 0) begin
                        $display("ALL TESTS PASSED");
                end else begin
                        if (DUT.u_assert.violations != 0)
                                $display("bus protocol assertions failed %0d times",
                                         DUT.u_assert.violations);
                        $display("SOME TESTS FAILED");
                end
                $finish;
        end

        initial begin
                #(WATCHDOG_NS);
                $display("watchdog expired after %0d ns, the DUT stopped making progress",
                         WATCHDOG_NS);
                $display("SOME TESTS FAILED");
                $finish;
        end
endmodule
